//--- vlog.f
+incdir+bench
logic/exec_pkg.sv
logic/alu.sv
logic/fpu.sv
logic/exec_ctrl.sv
logic/exec_unit.sv
bench/exec_unit_tb.sv

//--- Makefile
TOP := exec_unit_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/exec_model.svh
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// integer result of one alu operation.
function automatic exec_pkg::word_t alu_ref(
    input exec_pkg::alu_op_t op,
    input exec_pkg::word_t   a,
    input exec_pkg::word_t   b
);
    case (op)
        exec_pkg::alu_add:  return a + b;
        exec_pkg::alu_sub:  return a - b;
        exec_pkg::alu_and:  return a & b;
        exec_pkg::alu_or:   return a | b;
        exec_pkg::alu_xor:  return a ^ b;
        exec_pkg::alu_sll:  return a << b[4:0];
        exec_pkg::alu_srl:  return a >> b[4:0];
        exec_pkg::alu_sra:  return $signed(a) >>> b[4:0];
        exec_pkg::alu_slt:  return {31'd0, $signed(a) < $signed(b)};
        exec_pkg::alu_lt:   return {31'd0, $signed(a) < $signed(b)};
        exec_pkg::alu_ge:   return {31'd0, !($signed(a) < $signed(b))};
        exec_pkg::alu_sltu: return {31'd0, a < b};
        exec_pkg::alu_ltu:  return {31'd0, a < b};
        exec_pkg::alu_geu:  return {31'd0, !(a < b)};
        exec_pkg::alu_eq:   return {31'd0, a == b};
        exec_pkg::alu_ne:   return {31'd0, a != b};
        default:            return '0;
    endcase
endfunction

// single precision, truncated, zero and underflow give signed zero.
function automatic exec_pkg::word_t fpu_ref(
    input exec_pkg::fpu_op_t op,
    input exec_pkg::word_t   x,
    input exec_pkg::word_t   y
);
    logic        sx;
    logic        sy;
    logic        s;
    logic        zero;
    int          ex;
    int          ey;
    int          e;
    logic [23:0] mx;
    logic [23:0] my;
    logic [47:0] p;
    logic [25:0] m;
    logic [22:0] f;
    sx = x[31];
    sy = (op == exec_pkg::fpu_sub) ? !y[31] : y[31];
    ex = int'(x[30:23]);
    ey = int'(y[30:23]);
    mx = {1'b1, x[22:0]};
    my = {1'b1, y[22:0]};
    if (op == exec_pkg::fpu_mul) begin
        s = x[31] ^ y[31];
        e = ex + ey - 127;
        p = 48'(mx) * 48'(my);
        f = p[47] ? p[46:24] : p[45:23];
        e = p[47] ? e + 1 : e;
        zero = (p == '0);
    end else begin
        // larger magnitude goes first.
        if (y[30:0] > x[30:0]) begin
            {sx, ex, mx, sy, ey, my} = {sy, ey, my, sx, ex, mx};
        end
        s = sx;
        e = ex;
        my = (ex - ey > 23) ? 24'd0 : my >> (ex - ey);
        m = (sx == sy) ? {2'b0, mx} + {2'b0, my} : {2'b0, mx} - {2'b0, my};
        if (m[24]) begin
            m = m >> 1;
            e = e + 1;
        end
        while (m != '0 && !m[23]) begin
            m = m << 1;
            e = e - 1;
        end
        f = m[22:0];
        zero = (m == '0);
    end
    if (zero || e < 1) begin
        return {s, 31'd0};
    end
    return {s, 8'(e), f};
endfunction

// expected result packet for one request.
function automatic exec_pkg::exec_rsp_t exec_expect(input exec_pkg::exec_req_t r);
    exec_pkg::exec_rsp_t o;
    exec_pkg::word_t     a;
    a = alu_ref(r.alu_op, r.alu_pc ? r.pc : r.rs1_data, r.alu_src ? r.imm : r.rs2_data);
    o.mem_read    = r.mem_read;
    o.mem_write   = r.mem_write;
    o.reg_write   = r.reg_write;
    o.write_fp    = r.write_fp;
    o.rd          = r.rd;
    o.branch      = r.branch_uc || (r.branch_c && a != '0);
    o.branch_addr = !r.branch_rel ? a : (r.branch_uc ? r.pc + a : r.pc + r.imm);
    o.mem_addr    = a;
    o.mem_wdata   = r.rs2_data;
    if (r.use_fpu) begin
        o.wb_data = fpu_ref(r.fpu_op, r.rs1_data, r.rs2_data);
    end else begin
        o.wb_data = r.branch_uc ? r.pc + 32'd4 : a;
    end
    return o;
endfunction

`endif

//--- bench/exec_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit_tb;

    localparam int num_reqs = 400;
    // alu only, rsp_ready held high.
    localparam int num_flow = 40;
    localparam int limit_ns = (10 + 20 * num_reqs) * 10;

    logic                clk;
    logic                rst;
    logic                req_valid;
    logic                req_ready;
    exec_pkg::exec_req_t req;
    logic                rsp_valid;
    logic                rsp_ready;
    exec_pkg::exec_rsp_t rsp;

    integer              seed = 74931;
    int                  errors = 0;
    int                  received = 0;
    int                  cycles = 0;
    exec_pkg::exec_req_t pending[$];
    int                  accept_edge[$];

    `include "exec_model.svh"

    exec_unit dut (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    function automatic bit chance(input int pct);
        return ($unsigned($random(seed)) % 100) < pct;
    endfunction

    // normal number, exponent 100 to 150.
    function automatic exec_pkg::word_t fp_operand();
        logic [31:0] rnd;
        rnd = $random(seed);
        return {rnd[31], 8'(100 + rnd[30:23] % 51), rnd[22:0]};
    endfunction

    function automatic exec_pkg::exec_req_t random_req(input bit alu_only);
        exec_pkg::exec_req_t r;
        logic [31:0]         rnd;
        int                  kind;
        rnd = $random(seed);
        r = '0;
        r.pc        = {$random(seed)} & 32'hffff_fffc;
        r.imm       = $random(seed);
        r.rs1_data  = $random(seed);
        r.rs2_data  = chance(20) ? r.rs1_data : $random(seed);
        r.alu_op    = exec_pkg::alu_op_t'(rnd[3:0]);
        r.fpu_op    = exec_pkg::fpu_op_t'(2'(rnd[7:4] % 3));
        r.alu_pc    = rnd[8];
        r.alu_src   = rnd[9];
        r.mem_read  = rnd[10];
        r.mem_write = rnd[11];
        r.reg_write = rnd[12];
        r.write_fp  = rnd[13];
        r.rd        = rnd[18:14];
        kind = alu_only ? 0 : int'(rnd[27:20] % 10);
        if (kind >= 7) begin
            r.use_fpu  = 1'b1;
            r.rs1_data = fp_operand();
            // equal operands cancel on fsub and carry the exponent on fadd.
            r.rs2_data = (rnd[19] && rnd[28]) ? r.rs1_data : fp_operand();
        end else if (kind >= 5) begin
            r.branch_uc  = rnd[19];
            r.branch_c   = !rnd[19];
            r.branch_rel = rnd[28] || !rnd[19];
            if (r.branch_c) begin
                r.alu_pc  = 1'b0;
                r.alu_src = 1'b0;
                r.alu_op  = exec_pkg::alu_op_t'({1'b1, rnd[2:0]});
            end
        end
        return r;
    endfunction

    function automatic exec_pkg::word_t flag_bits(input exec_pkg::exec_rsp_t p);
        return {22'd0, p.mem_read, p.mem_write, p.reg_write, p.write_fp, p.rd, p.branch};
    endfunction

    task automatic check_field(input string tag, input string field,
                               input exec_pkg::word_t expected, input exec_pkg::word_t actual);
        assert (actual === expected) else begin
            errors++;
            $display("CHECK FAILED %s %s expected %h actual %h", tag, field, expected, actual);
        end
    endtask

    task automatic print_summary();
        $display("errors: %0d, results: %0d of %0d", errors, received, num_reqs);
    endtask

    // results leave in issue order.
    always @(negedge clk) begin
        exec_pkg::exec_req_t r;
        exec_pkg::exec_rsp_t e;
        string               tag;
        int                  acc;
        if (!rst && rsp_valid && rsp_ready) begin
            assert (pending.size() > 0) else begin
                errors++;
                $display("result at cycle %0d arrived with no request pending", cycles);
            end
            if (pending.size() > 0) begin
                r = pending.pop_front();
                acc = accept_edge.pop_front();
                e = exec_expect(r);
                if (r.use_fpu) begin
                    tag = $sformatf("fpu #%0d", received);
                end else if (r.branch_uc || r.branch_c) begin
                    tag = $sformatf("branch #%0d", received);
                end else begin
                    tag = $sformatf("alu #%0d", received);
                end
                check_field(tag, "flags", flag_bits(e), flag_bits(rsp));
                check_field(tag, "branch_addr", e.branch_addr, rsp.branch_addr);
                check_field(tag, "mem_addr", e.mem_addr, rsp.mem_addr);
                check_field(tag, "mem_wdata", e.mem_wdata, rsp.mem_wdata);
                check_field(tag, "wb_data", e.wb_data, rsp.wb_data);
                if (received < num_flow) begin
                    check_field(tag, "transfer edge", acc + 1, cycles + 1);
                end
                received++;
            end
        end
    end

    initial begin
        bit go;
        int sent;
        int edge_no;
        rst = 1'b1;
        req_valid = 1'b0;
        req = '0;
        rsp_ready = 1'b0;
        go = 1'b0;
        sent = 0;
        edge_no = 0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        assert (!rsp_valid && req_ready) else begin
            errors++;
            $display("after reset rsp_valid is not low or req_ready is not high");
        end
        @(posedge clk);
        #1;
        while (sent < num_reqs) begin
            if (!req_valid && (sent < num_flow || chance(80))) begin
                req = random_req(sent < num_flow);
                req_valid = 1'b1;
            end
            rsp_ready = (sent <= num_flow) ? 1'b1 : chance(70);
            @(negedge clk);
            go = req_valid && req_ready;
            edge_no = cycles + 1;
            if (sent < num_flow) begin
                assert (go) else begin
                    errors++;
                    $display("back-to-back alu request %0d was not accepted", sent);
                end
            end
            @(posedge clk);
            if (go) begin
                pending.push_back(req);
                accept_edge.push_back(edge_no);
                sent++;
            end
            #1;
            if (go) begin
                req_valid = 1'b0;
            end
        end
        while (received < num_reqs) begin
            rsp_ready = chance(70);
            @(posedge clk);
            #1;
        end
        // a duplicated result would still show up here.
        rsp_ready = 1'b1;
        repeat (5) @(posedge clk);
        print_summary();
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(limit_ns);
        $display("timeout after %0d ns, the run did not complete", limit_ns);
        print_summary();
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid,
    output logic                req_ready,
    input  exec_pkg::exec_req_t req,
    output logic                rsp_valid,
    input  logic                rsp_ready,
    output exec_pkg::exec_rsp_t rsp
);

    exec_pkg::word_t   alu_a;
    exec_pkg::word_t   alu_b;
    exec_pkg::alu_op_t alu_op;
    exec_pkg::word_t   alu_result;
    logic              fpu_start;
    exec_pkg::fpu_op_t fpu_op;
    exec_pkg::word_t   fpu_x;
    exec_pkg::word_t   fpu_y;
    logic              fpu_busy;
    logic              fpu_done;
    exec_pkg::word_t   fpu_result;

    exec_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp        (rsp),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .alu_op     (alu_op),
        .alu_result (alu_result),
        .fpu_start  (fpu_start),
        .fpu_op     (fpu_op),
        .fpu_x      (fpu_x),
        .fpu_y      (fpu_y),
        .fpu_busy   (fpu_busy),
        .fpu_done   (fpu_done),
        .fpu_result (fpu_result)
    );

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result)
    );

    fpu u_fpu (
        .clk    (clk),
        .rst    (rst),
        .start  (fpu_start),
        .op     (fpu_op),
        .x      (fpu_x),
        .y      (fpu_y),
        .busy   (fpu_busy),
        .done   (fpu_done),
        .result (fpu_result)
    );

endmodule

`default_nettype wire

//--- logic/exec_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module exec_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid,
    output logic                req_ready,
    input  exec_pkg::exec_req_t req,
    output logic                rsp_valid,
    input  logic                rsp_ready,
    output exec_pkg::exec_rsp_t rsp,
    output exec_pkg::word_t     alu_a,
    output exec_pkg::word_t     alu_b,
    output exec_pkg::alu_op_t   alu_op,
    input  exec_pkg::word_t     alu_result,
    output logic                fpu_start,
    output exec_pkg::fpu_op_t   fpu_op,
    output exec_pkg::word_t     fpu_x,
    output exec_pkg::word_t     fpu_y,
    input  logic                fpu_busy,
    input  logic                fpu_done,
    input  exec_pkg::word_t     fpu_result
);

    typedef enum logic [1:0] {
        idle,
        fpu_wait,
        hold
    } ctrl_state_t;

    ctrl_state_t state;
    logic        accept;
    logic        leave;
    logic        fpu_finish;

    function automatic exec_pkg::exec_rsp_t build_rsp(
        input exec_pkg::exec_req_t r,
        input exec_pkg::word_t     alu_res
    );
        exec_pkg::exec_rsp_t o;
        o.mem_read  = r.mem_read;
        o.mem_write = r.mem_write;
        o.reg_write = r.reg_write;
        o.write_fp  = r.write_fp;
        o.rd        = r.rd;
        o.branch    = r.branch_uc || (r.branch_c && (alu_res != '0));
        if (!r.branch_rel) begin
            o.branch_addr = alu_res;
        end else if (r.branch_uc) begin
            o.branch_addr = r.pc + alu_res;
        end else begin
            o.branch_addr = r.pc + r.imm;
        end
        o.mem_addr  = alu_res;
        o.mem_wdata = r.rs2_data;
        // fpu instructions replace this on done.
        o.wb_data   = r.branch_uc ? r.pc + 32'd4 : alu_res;
        return o;
    endfunction

    // operands come from the live request.
    assign alu_a  = req.alu_pc ? req.pc : req.rs1_data;
    assign alu_b  = req.alu_src ? req.imm : req.rs2_data;
    assign alu_op = req.alu_op;

    assign fpu_op = req.fpu_op;
    assign fpu_x  = req.rs1_data;
    assign fpu_y  = req.rs2_data;

    // the fpu is idle whenever this stage is idle or holding a result.
    assign rsp_valid  = state == hold;
    assign leave      = rsp_valid && rsp_ready;
    assign req_ready  = state == idle || leave;
    assign accept     = req_valid && req_ready;
    assign fpu_start  = accept && req.use_fpu;
    assign fpu_finish = state == fpu_wait && fpu_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else if (accept) begin
            state <= req.use_fpu ? fpu_wait : hold;
        end else if (fpu_finish) begin
            state <= hold;
        end else if (leave) begin
            state <= idle;
        end
    end

    // the result register also keeps the flags of a pending fpu op.
    always_ff @(posedge clk) begin
        if (rst) begin
            rsp.mem_read  <= 1'b0;
            rsp.mem_write <= 1'b0;
            rsp.reg_write <= 1'b0;
            rsp.write_fp  <= 1'b0;
            rsp.branch    <= 1'b0;
        end else if (accept) begin
            rsp <= build_rsp(req, alu_result);
        end else if (fpu_finish) begin
            rsp.wb_data <= fpu_result;
        end
    end

    a_rsp_stable: assert property (@(posedge clk) disable iff (rst)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        fpu_start |-> !fpu_busy);

endmodule

`default_nettype wire

//--- logic/fpu.sv
`timescale 1ns/1ps
`default_nettype none

module fpu (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  exec_pkg::fpu_op_t op,
    input  exec_pkg::word_t   x,
    input  exec_pkg::word_t   y,
    output logic              busy,
    output logic              done,
    output exec_pkg::word_t   result
);

    typedef enum logic [2:0] {
        idle,
        unpack,
        align,
        compute,
        normalise,
        pack
    } fpu_state_t;

    fpu_state_t        state;
    exec_pkg::fpu_op_t op_q;
    exec_pkg::word_t   x_q;
    exec_pkg::word_t   y_q;
    logic              sign_q;
    logic              sub_q;
    logic signed [9:0] exp_q;
    logic [7:0]        shift_q;
    logic [23:0]       big_m;
    logic [23:0]       sml_m;
    logic [24:0]       sum_q;
    logic [47:0]       prod_q;

    logic              y_sign;
    logic              swap;
    exec_pkg::word_t   big_w;
    exec_pkg::word_t   sml_w;
    logic [24:0]       sum_d;
    logic signed [9:0] exp_d;
    logic              norm_ok;
    logic              res_zero;
    logic signed [9:0] res_exp;
    logic [22:0]       res_frac;

    // exponent zero counts as a zero operand.
    function automatic logic [23:0] mant_of(input exec_pkg::word_t w);
        return {(w[30:23] != 8'd0), w[22:0]};
    endfunction

    // add/sub orders the operands by magnitude.
    assign y_sign = y_q[31] ^ (op_q == exec_pkg::fpu_sub);
    assign swap   = y_q[30:0] > x_q[30:0];
    assign big_w  = swap ? {y_sign, y_q[30:0]} : x_q;
    assign sml_w  = swap ? x_q : {y_sign, y_q[30:0]};

    always_comb begin
        sum_d = sum_q;
        exp_d = exp_q;
        if (state == compute) begin
            if (sub_q) begin
                sum_d = {1'b0, big_m} - {1'b0, sml_m};
            end else begin
                sum_d = {1'b0, big_m} + {1'b0, sml_m};
            end
        end else if (sum_q[24]) begin
            sum_d = sum_q >> 1;
            exp_d = exp_q + 10'sd1;
        end else if (sum_q[22]) begin
            sum_d = sum_q << 1;
            exp_d = exp_q - 10'sd1;
        end else begin
            sum_d = sum_q << 2;
            exp_d = exp_q - 10'sd2;
        end
    end

    assign norm_ok = (sum_d[24:23] == 2'b01) || (sum_d == 25'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            case (state)
                idle:      if (start) state <= unpack;
                unpack:    state <= (op_q == exec_pkg::fpu_mul) ? compute : align;
                align:     state <= compute;
                compute:   state <= (op_q == exec_pkg::fpu_mul || norm_ok) ? pack : normalise;
                normalise: if (norm_ok) state <= pack;
                pack:      state <= idle;
                default:   state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && start) begin
            op_q <= op;
            x_q  <= x;
            y_q  <= y;
        end
        if (state == unpack) begin
            if (op_q == exec_pkg::fpu_mul) begin
                sign_q <= x_q[31] ^ y_q[31];
                exp_q  <= $signed({2'b00, x_q[30:23]}) + $signed({2'b00, y_q[30:23]})
                          - 10'sd127;
                big_m  <= mant_of(x_q);
                sml_m  <= mant_of(y_q);
            end else begin
                sign_q  <= big_w[31];
                sub_q   <= big_w[31] ^ sml_w[31];
                exp_q   <= $signed({2'b00, big_w[30:23]});
                shift_q <= big_w[30:23] - sml_w[30:23];
                big_m   <= mant_of(big_w);
                sml_m   <= mant_of(sml_w);
            end
        end
        // no sticky bit, shifted-out bits are lost.
        if (state == align) begin
            sml_m <= (shift_q > 8'd23) ? 24'd0 : sml_m >> shift_q;
        end
        if (state == compute && op_q == exec_pkg::fpu_mul) begin
            prod_q <= big_m * sml_m;
        end
        if ((state == compute && op_q != exec_pkg::fpu_mul) || state == normalise) begin
            sum_q <= sum_d;
            exp_q <= exp_d;
        end
    end

    // truncating pack, underflow flushes to signed zero.
    always_comb begin
        res_zero = (sum_q == 25'd0);
        res_exp  = exp_q;
        res_frac = sum_q[22:0];
        if (op_q == exec_pkg::fpu_mul) begin
            res_zero = (prod_q == 48'd0);
            if (prod_q[47]) begin
                res_exp  = exp_q + 10'sd1;
                res_frac = prod_q[46:24];
            end else begin
                res_frac = prod_q[45:23];
            end
        end
        if (res_zero || res_exp < 10'sd1) begin
            result = {sign_q, 31'd0};
        end else begin
            result = {sign_q, res_exp[7:0], res_frac};
        end
    end

    assign busy = state != idle;
    assign done = state == pack;

    a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done);

endmodule

`default_nettype wire

//--- logic/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  exec_pkg::word_t   a,
    input  exec_pkg::word_t   b,
    input  exec_pkg::alu_op_t op,
    output exec_pkg::word_t   result
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;
    logic       eq;

    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;
    assign eq    = a == b;

    always_comb begin
        case (op)
            exec_pkg::alu_add:
                result = a + b;
            exec_pkg::alu_sub:
                result = a - b;
            exec_pkg::alu_and:
                result = a & b;
            exec_pkg::alu_or:
                result = a | b;
            exec_pkg::alu_xor:
                result = a ^ b;
            exec_pkg::alu_sll:
                result = a << shamt;
            exec_pkg::alu_srl:
                result = a >> shamt;
            exec_pkg::alu_sra:
                result = $signed(a) >>> shamt;
            // slt and lt differ only in encoding.
            exec_pkg::alu_slt,
            exec_pkg::alu_lt:
                result = {31'd0, lt_s};
            exec_pkg::alu_sltu,
            exec_pkg::alu_ltu:
                result = {31'd0, lt_u};
            exec_pkg::alu_eq:
                result = {31'd0, eq};
            exec_pkg::alu_ne:
                result = {31'd0, !eq};
            exec_pkg::alu_ge:
                result = {31'd0, !lt_s};
            exec_pkg::alu_geu:
                result = {31'd0, !lt_u};
            default:
                result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/exec_pkg.sv
`default_nettype none

package exec_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_idx_t;

    // compare ops give 1 or 0.
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu,
        alu_eq,
        alu_ne,
        alu_lt,
        alu_ge,
        alu_ltu,
        alu_geu
    } alu_op_t;

    typedef enum logic [1:0] {
        fpu_add,
        fpu_sub,
        fpu_mul
    } fpu_op_t;

    typedef struct packed {
        word_t    pc;
        word_t    imm;
        word_t    rs1_data;
        word_t    rs2_data;
        alu_op_t  alu_op;
        fpu_op_t  fpu_op;
        logic     use_fpu;
        logic     alu_pc;
        logic     alu_src;
        logic     branch_uc;
        logic     branch_c;
        logic     branch_rel;
        logic     mem_read;
        logic     mem_write;
        logic     reg_write;
        logic     write_fp;
        reg_idx_t rd;
    } exec_req_t;

    typedef struct packed {
        logic     mem_read;
        logic     mem_write;
        logic     reg_write;
        logic     write_fp;
        reg_idx_t rd;
        logic     branch;
        word_t    branch_addr;
        word_t    mem_addr;
        word_t    mem_wdata;
        word_t    wb_data;
    } exec_rsp_t;

endpackage

`default_nettype wire
